// File: verilog/spmv_pkg.sv
package spmv_pkg;

    // bus widths
    localparam int ADDR_W = 48;
    localparam int DATA_W = 64;
    localparam int COL_W = 32;
    localparam int ELEM_BYTES = 8;

    // opcode word layout
    localparam int OP_CODE_LSB = 0;
    localparam int OP_CODE_W = 4;
    localparam int OP_PE_LSB = 4;
    localparam int OP_PE_W = 8;
    localparam int OP_IDX_LSB = 12;
    localparam int OP_IDX_W = 4;
    localparam int OP_DATA_LSB = 16;

    // working register indices, REG_COUNT doubles as the register count
    localparam int REG_Y_ADDR = 0;
    localparam int REG_Y_END = 1;
    localparam int REG_X_BASE = 2;
    localparam int REG_COUNT = 3;

    // packed request is {d_or_tag, addr, st, ld}
    localparam int REQ_W = DATA_W + ADDR_W + 2;

    localparam int FIFO_DEPTH = 32;
    localparam int FIFO_ALMOST_FULL = 4;

    localparam int STEADY_IDLE_CYCLES = 32;

    typedef enum logic [OP_CODE_W-1:0] {
        OP_NOP    = 4'd0,
        OP_RST    = 4'd1,
        OP_LD     = 4'd2,
        OP_READ   = 4'd3,
        OP_STEADY = 4'd4,
        OP_RETURN = 4'd5
    } op_code_e;

    typedef enum logic {
        ST_IDLE,
        ST_STEADY
    } pe_state_e;

endpackage

// File: verilog/std_fifo.sv
`timescale 1ns/1ps

module std_fifo #(
    parameter int width = 64,
    parameter int depth = 32,
    parameter int almost_full_count = 4
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic             pop,
    input  logic [width-1:0] d,
    output logic [width-1:0] q,
    output logic             empty,
    output logic             full,
    output logic             almost_full
);

    logic [width-1:0]             mem [depth];
    logic [$clog2(depth)-1:0]     wr_ptr;
    logic [$clog2(depth)-1:0]     rd_ptr;
    logic [$clog2(depth + 1)-1:0] count;
    logic [$clog2(depth + 1)-1:0] count_next;
    logic                         do_push;
    logic                         do_pop;

    assign empty = count == 0;
    assign full = count == depth;
    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    // show-ahead head entry
    assign q = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (do_push && !do_pop) begin
            count_next = count + 1'b1;
        end else if (do_pop && !do_push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            almost_full <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == depth - 1) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == depth - 1) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // rises with almost_full_count entries still free
            almost_full <= count_next >= depth - almost_full_count;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= d;
        end
    end

endmodule

// File: verilog/mem_request_gen.sv
`timescale 1ns/1ps

module mem_request_gen (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        soft_rst,
    input  logic                        val_push,
    input  logic [spmv_pkg::DATA_W-1:0] val,
    input  logic                        col_push,
    input  logic [spmv_pkg::COL_W-1:0]  col,
    input  logic [spmv_pkg::ADDR_W-1:0] y_addr,
    input  logic                        y_at_end,
    input  logic [spmv_pkg::ADDR_W-1:0] x_base,
    input  logic                        fifo_almost_full,
    output logic                        val_stall,
    output logic                        col_stall,
    output logic                        store_taken,
    output logic                        fifo_push,
    output logic [spmv_pkg::REQ_W-1:0]  fifo_d
);
    import spmv_pkg::*;

    logic              val_acc;
    logic              col_acc;
    logic [ADDR_W-1:0] load_addr;
    logic              hold_valid;
    logic [ADDR_W-1:0] hold_addr;
    logic              req_valid;
    logic              req_st;
    logic [ADDR_W-1:0] req_addr;
    logic [DATA_W-1:0] req_d;

    assign val_stall = fifo_almost_full;
    assign col_stall = hold_valid || fifo_almost_full;
    assign val_acc = val_push && !val_stall;
    assign col_acc = col_push && !col_stall;

    // values past y_end are accepted and dropped
    assign store_taken = val_acc && !y_at_end;
    assign load_addr = x_base + ADDR_W'(col) * ADDR_W'(ELEM_BYTES);

    // store first, then a held load, then a fresh load
    always_comb begin
        req_valid = 1'b1;
        req_st = 1'b0;
        req_addr = load_addr;
        req_d = DATA_W'(1);
        if (store_taken) begin
            req_st = 1'b1;
            req_addr = y_addr;
            req_d = val;
        end else if (hold_valid) begin
            req_addr = hold_addr;
        end else if (!col_acc) begin
            req_valid = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || soft_rst) begin
            hold_valid <= 1'b0;
            fifo_push <= 1'b0;
        end else begin
            fifo_push <= req_valid;
            // hold only fills when a store took the slot
            hold_valid <= store_taken && (hold_valid || col_acc);
        end
    end

    always_ff @(posedge clk) begin
        if (col_acc) begin
            hold_addr <= load_addr;
        end
        fifo_d <= {req_d, req_addr, req_st, !req_st};
    end

endmodule

// File: verilog/mem_request_issuer.sv
`timescale 1ns/1ps

module mem_request_issuer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_mem_stall,
    input  logic [spmv_pkg::REQ_W-1:0]  fifo_q,
    input  logic                        fifo_empty,
    output logic                        fifo_pop,
    output logic                        req_mem_ld,
    output logic                        req_mem_st,
    output logic [spmv_pkg::ADDR_W-1:0] req_mem_addr,
    output logic [spmv_pkg::DATA_W-1:0] req_mem_d_or_tag
);
    import spmv_pkg::*;

    logic stall_r;

    assign fifo_pop = !fifo_empty && !stall_r;

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_r <= 1'b0;
            req_mem_ld <= 1'b0;
            req_mem_st <= 1'b0;
        end else begin
            stall_r <= req_mem_stall;
            // strobes only in the cycle after a pop
            req_mem_ld <= fifo_pop && fifo_q[0];
            req_mem_st <= fifo_pop && fifo_q[1];
        end
    end

    always_ff @(posedge clk) begin
        req_mem_addr <= fifo_q[2 +: ADDR_W];
        req_mem_d_or_tag <= fifo_q[2 + ADDR_W +: DATA_W];
    end

endmodule

// File: verilog/pe_op_ring.sv
`timescale 1ns/1ps

module pe_op_ring #(
    parameter int pe_id = 0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [spmv_pkg::DATA_W-1:0] op_in,
    input  logic                        busy_in,
    input  logic                        store_taken,
    input  logic                        fifo_empty,
    output logic [spmv_pkg::DATA_W-1:0] op_out,
    output logic                        busy_out,
    output logic [spmv_pkg::ADDR_W-1:0] y_addr,
    output logic                        y_at_end,
    output logic [spmv_pkg::ADDR_W-1:0] x_base,
    output logic                        soft_rst
);
    import spmv_pkg::*;

    logic [DATA_W-1:0]   op_s1;
    logic [DATA_W-1:0]   op_next;
    logic [ADDR_W-1:0]   regs [REG_COUNT];
    op_code_e            code;
    logic [OP_IDX_W-1:0] idx;
    logic                targeted;
    logic                idx_valid;
    logic                ld_hit;
    logic                read_hit;
    logic                steady_hit;
    logic                rst_hit;
    pe_state_e           state;
    logic [$clog2(STEADY_IDLE_CYCLES):0] idle_cnt;
    logic                idle;
    logic                busy_in_r;

    // decode happens on the first pipeline stage
    assign code = op_code_e'(op_s1[OP_CODE_LSB +: OP_CODE_W]);
    assign idx = op_s1[OP_IDX_LSB +: OP_IDX_W];
    // top bit of the PE field is broadcast
    assign targeted = op_s1[OP_PE_LSB + OP_PE_W - 1] ||
                      (op_s1[OP_PE_LSB +: OP_PE_W] == OP_PE_W'(pe_id));
    assign idx_valid = idx < REG_COUNT;

    assign ld_hit = targeted && code == OP_LD && idx_valid;
    assign read_hit = targeted && code == OP_READ && idx_valid;
    assign steady_hit = targeted && code == OP_STEADY;
    assign rst_hit = targeted && code == OP_RST;

    assign y_addr = regs[REG_Y_ADDR];
    assign x_base = regs[REG_X_BASE];
    assign y_at_end = regs[REG_Y_ADDR] == regs[REG_Y_END];

    // READ is answered in the same ring slot
    always_comb begin
        op_next = op_s1;
        if (read_hit) begin
            op_next[OP_CODE_LSB +: OP_CODE_W] = OP_RETURN;
            op_next[OP_PE_LSB +: OP_PE_W] = OP_PE_W'(pe_id);
            op_next[OP_DATA_LSB +: ADDR_W] = regs[idx[1:0]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_s1 <= DATA_W'(OP_NOP);
            op_out <= DATA_W'(OP_NOP);
        end else begin
            op_s1 <= op_in;
            op_out <= op_next;
        end
    end

    // LD wins over the store advance in the working registers
    always_ff @(posedge clk) begin
        if (rst) begin
            soft_rst <= 1'b0;
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            soft_rst <= rst_hit;
            if (store_taken) begin
                regs[REG_Y_ADDR] <= regs[REG_Y_ADDR] + ADDR_W'(ELEM_BYTES);
            end
            if (ld_hit) begin
                regs[idx[1:0]] <= op_s1[OP_DATA_LSB +: ADDR_W];
            end
            if (rst_hit) begin
                for (int i = 0; i < REG_COUNT; i++) begin
                    regs[i] <= '0;
                end
            end
        end
    end

    // steady ends once the y stream is done and nothing is queued
    assign idle = y_at_end && fifo_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_IDLE;
            idle_cnt <= '0;
        end else begin
            if (state == ST_STEADY) begin
                if (!idle) begin
                    idle_cnt <= '0;
                end else if (idle_cnt == STEADY_IDLE_CYCLES - 1) begin
                    state <= ST_IDLE;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
            if (steady_hit) begin
                state <= ST_STEADY;
                idle_cnt <= '0;
            end
            if (rst_hit) begin
                state <= ST_IDLE;
                idle_cnt <= '0;
            end
        end
    end

    // busy chain through two register stages
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_in_r <= 1'b0;
            busy_out <= 1'b0;
        end else begin
            busy_in_r <= busy_in;
            busy_out <= busy_in_r || state == ST_STEADY;
        end
    end

endmodule

// File: verilog/spmv_pe.sv
`timescale 1ns/1ps

module spmv_pe #(
    parameter int pe_id = 0
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [spmv_pkg::DATA_W-1:0] op_in,
    input  logic                        busy_in,
    input  logic                        val_push,
    input  logic [spmv_pkg::DATA_W-1:0] val,
    input  logic                        col_push,
    input  logic [spmv_pkg::COL_W-1:0]  col,
    input  logic                        req_mem_stall,
    output logic [spmv_pkg::DATA_W-1:0] op_out,
    output logic                        busy_out,
    output logic                        val_stall,
    output logic                        col_stall,
    output logic                        req_mem_ld,
    output logic                        req_mem_st,
    output logic [spmv_pkg::ADDR_W-1:0] req_mem_addr,
    output logic [spmv_pkg::DATA_W-1:0] req_mem_d_or_tag
);
    import spmv_pkg::*;

    // control block to request generator
    logic [ADDR_W-1:0] y_addr;
    logic [ADDR_W-1:0] x_base;
    logic              y_at_end;
    logic              store_taken;
    logic              soft_rst;

    // request FIFO
    logic              fifo_push;
    logic [REQ_W-1:0]  fifo_d;
    logic              fifo_pop;
    logic [REQ_W-1:0]  fifo_q;
    logic              fifo_empty;
    logic              fifo_almost_full;

    pe_op_ring #(
        .pe_id(pe_id)
    ) op_ring_inst (
        .clk        (clk),
        .rst        (rst),
        .op_in      (op_in),
        .busy_in    (busy_in),
        .store_taken(store_taken),
        .fifo_empty (fifo_empty),
        .op_out     (op_out),
        .busy_out   (busy_out),
        .y_addr     (y_addr),
        .y_at_end   (y_at_end),
        .x_base     (x_base),
        .soft_rst   (soft_rst)
    );

    mem_request_gen req_gen_inst (
        .clk             (clk),
        .rst             (rst),
        .soft_rst        (soft_rst),
        .val_push        (val_push),
        .val             (val),
        .col_push        (col_push),
        .col             (col),
        .y_addr          (y_addr),
        .y_at_end        (y_at_end),
        .x_base          (x_base),
        .fifo_almost_full(fifo_almost_full),
        .val_stall       (val_stall),
        .col_stall       (col_stall),
        .store_taken     (store_taken),
        .fifo_push       (fifo_push),
        .fifo_d          (fifo_d)
    );

    // RST opcode flushes queued requests as well
    std_fifo #(
        .width            (REQ_W),
        .depth            (FIFO_DEPTH),
        .almost_full_count(FIFO_ALMOST_FULL)
    ) req_fifo_inst (
        .clk        (clk),
        .rst        (rst || soft_rst),
        .push       (fifo_push),
        .pop        (fifo_pop),
        .d          (fifo_d),
        .q          (fifo_q),
        .empty      (fifo_empty),
        .full       (),
        .almost_full(fifo_almost_full)
    );

    mem_request_issuer issuer_inst (
        .clk             (clk),
        .rst             (rst),
        .req_mem_stall   (req_mem_stall),
        .fifo_q          (fifo_q),
        .fifo_empty      (fifo_empty),
        .fifo_pop        (fifo_pop),
        .req_mem_ld      (req_mem_ld),
        .req_mem_st      (req_mem_st),
        .req_mem_addr    (req_mem_addr),
        .req_mem_d_or_tag(req_mem_d_or_tag)
    );

endmodule

// File: tests/spmv_pe_tb.sv
`timescale 1ns/1ps

module spmv_pe_tb;
    import spmv_pkg::*;

    localparam int CYCLE_LIMIT = 4000;
    localparam logic [7:0] MY_PE = 8'd5;
    localparam logic [7:0] BCAST = 8'h80;

    logic              clk;
    logic              rst;
    logic [DATA_W-1:0] op_in;
    logic              busy_in;
    logic              val_push;
    logic [DATA_W-1:0] val;
    logic              col_push;
    logic [COL_W-1:0]  col;
    logic              req_mem_stall;
    logic [DATA_W-1:0] op_out;
    logic              busy_out;
    logic              val_stall;
    logic              col_stall;
    logic              req_mem_ld;
    logic              req_mem_st;
    logic [ADDR_W-1:0] req_mem_addr;
    logic [DATA_W-1:0] req_mem_d_or_tag;

    // reference model state
    logic [DATA_W-1:0]          exp_op;
    logic [DATA_W-1:0]          op_pipe0;
    logic [DATA_W-1:0]          op_pipe1;
    logic [ADDR_W-1:0]          reg_model [3];
    logic [1+ADDR_W+DATA_W-1:0] exp_q [$];
    logic                       held;
    logic [ADDR_W-1:0]          held_addr;
    logic                       chk_valid;
    logic                       chk_st;
    logic [ADDR_W-1:0]          chk_addr;
    logic [DATA_W-1:0]          chk_d;
    logic                       busy_pass_chk;
    logic                       rst_q = 1'b0;
    logic                       rst_q2 = 1'b0;
    int                         errors = 0;
    int                         n_req = 0;
    int                         cycles = 0;

    spmv_pe #(
        .pe_id(5)
    ) spmv_pe_inst (
        .clk             (clk),
        .rst             (rst),
        .op_in           (op_in),
        .busy_in         (busy_in),
        .val_push        (val_push),
        .val             (val),
        .col_push        (col_push),
        .col             (col),
        .req_mem_stall   (req_mem_stall),
        .op_out          (op_out),
        .busy_out        (busy_out),
        .val_stall       (val_stall),
        .col_stall       (col_stall),
        .req_mem_ld      (req_mem_ld),
        .req_mem_st      (req_mem_st),
        .req_mem_addr    (req_mem_addr),
        .req_mem_d_or_tag(req_mem_d_or_tag)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("error: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("requests checked %0d, errors %0d", n_req, errors + 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ring model, two stages like the element
    always @(posedge clk) begin
        rst_q <= rst;
        rst_q2 <= rst_q;
        if (rst) begin
            op_pipe0 <= '0;
            op_pipe1 <= '0;
        end else begin
            op_pipe0 <= exp_op;
            op_pipe1 <= op_pipe0;
        end
    end

    // port strobes are stable at the falling edge
    always @(negedge clk) begin
        chk_valid = 1'b0;
        if ((req_mem_ld || req_mem_st) && exp_q.size() > 0) begin
            {chk_st, chk_addr, chk_d} = exp_q.pop_front();
            chk_valid = 1'b1;
            n_req++;
        end
    end

    assert property (@(posedge clk) (rst_q || rst_q2) |-> op_out == '0)
        else begin
            errors++;
            $display("error: t=%0t op_out got %h expected %h", $time, $sampled(op_out), 64'd0);
        end
    assert property (@(posedge clk) (rst_q || rst_q2) |->
                     !(req_mem_ld || req_mem_st || busy_out || val_stall || col_stall))
        else begin
            errors++;
            $display("error: t=%0t a strobe, stall or busy output is high around reset", $time);
        end
    assert property (@(posedge clk) disable iff (rst) op_out == op_pipe1)
        else begin
            errors++;
            $display("error: t=%0t op_out got %h expected %h",
                     $time, $sampled(op_out), $sampled(op_pipe1));
        end
    assert property (@(posedge clk) disable iff (rst) (req_mem_ld || req_mem_st) |-> chk_valid)
        else begin
            errors++;
            $display("error: t=%0t request on the memory port that was never expected", $time);
        end
    assert property (@(posedge clk) disable iff (rst) chk_valid |-> req_mem_st == chk_st)
        else begin
            errors++;
            $display("error: t=%0t req_mem_st got %b expected %b",
                     $time, $sampled(req_mem_st), $sampled(chk_st));
        end
    assert property (@(posedge clk) disable iff (rst) chk_valid |-> req_mem_ld == !chk_st)
        else begin
            errors++;
            $display("error: t=%0t req_mem_ld got %b expected %b",
                     $time, $sampled(req_mem_ld), !$sampled(chk_st));
        end
    assert property (@(posedge clk) disable iff (rst) chk_valid |-> req_mem_addr == chk_addr)
        else begin
            errors++;
            $display("error: t=%0t req_mem_addr got %h expected %h",
                     $time, $sampled(req_mem_addr), $sampled(chk_addr));
        end
    assert property (@(posedge clk) disable iff (rst) chk_valid |-> req_mem_d_or_tag == chk_d)
        else begin
            errors++;
            $display("error: t=%0t req_mem_d_or_tag got %h expected %h",
                     $time, $sampled(req_mem_d_or_tag), $sampled(chk_d));
        end
    assert property (@(posedge clk) disable iff (rst)
                     (req_mem_ld || req_mem_st) |-> !$past(req_mem_stall, 2))
        else begin
            errors++;
            $display("error: t=%0t memory strobe issued right after a sampled stall", $time);
        end
    assert property (@(posedge clk) disable iff (rst)
                     busy_pass_chk |-> busy_out == $past(busy_in, 2))
        else begin
            errors++;
            $display("error: t=%0t busy_out got %b expected %b",
                     $time, $sampled(busy_out), $past(busy_in, 2));
        end

    function automatic logic [DATA_W-1:0] make_op(input logic [3:0] code, input logic [7:0] pe,
                                                  input logic [3:0] idx,
                                                  input logic [ADDR_W-1:0] data);
        return {data, idx, pe, code};
    endfunction

    task automatic send_op(input logic [DATA_W-1:0] word, input logic [DATA_W-1:0] expected);
        @(posedge clk);
        #2;
        op_in = word;
        exp_op = expected;
        @(posedge clk);
        #2;
        op_in = '0;
        exp_op = '0;
    endtask

    task automatic load_reg(input logic [3:0] idx, input logic [7:0] pe,
                            input logic [ADDR_W-1:0] value);
        reg_model[idx] = value;
        send_op(make_op(OP_LD, pe, idx, value), make_op(OP_LD, pe, idx, value));
    endtask

    task automatic read_reg(input logic [3:0] idx, input logic [7:0] pe);
        send_op(make_op(OP_READ, pe, idx, '0), make_op(OP_RETURN, MY_PE, idx, reg_model[idx]));
    endtask

    // one cycle of pushes plus the expected requests they produce
    task automatic push_cycle(input logic want_val, input logic [DATA_W-1:0] v,
                              input logic want_col, input logic [COL_W-1:0] c);
        logic              st;
        logic [ADDR_W-1:0] la;
        @(posedge clk);
        #2;
        val_push = want_val && !val_stall;
        val = v;
        col_push = want_col && !col_stall;
        col = c;
        st = val_push && (reg_model[0] != reg_model[1]);
        la = reg_model[2] + ({16'd0, c} << 3);
        if (st) begin
            exp_q.push_back({1'b1, reg_model[0], v});
            reg_model[0] = reg_model[0] + ADDR_W'(ELEM_BYTES);
        end else if (held) begin
            exp_q.push_back({1'b0, held_addr, 64'd1});
            held = 1'b0;
        end
        if (col_push && st) begin
            held = 1'b1;
            held_addr = la;
        end else if (col_push) begin
            exp_q.push_back({1'b0, la, 64'd1});
        end
    endtask

    task automatic drain_requests();
        while (exp_q.size() != 0 || held) begin
            push_cycle(1'b0, '0, 1'b0, '0);
        end
    endtask

    initial begin
        logic [DATA_W-1:0] v_rand;
        logic [COL_W-1:0]  c_rand;
        logic              want_v;
        logic              want_c;
        int                wait_cnt;
        void'($urandom(32'hc7f6_bad2));
        rst = 1'b1;
        op_in = '0;
        busy_in = 1'b0;
        val_push = 1'b0;
        val = '0;
        col_push = 1'b0;
        col = '0;
        req_mem_stall = 1'b0;
        exp_op = '0;
        held = 1'b0;
        chk_valid = 1'b0;
        busy_pass_chk = 1'b1;
        reg_model[0] = '0;
        reg_model[1] = '0;
        reg_model[2] = '0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;

        // other PE, passes through untouched
        send_op(make_op(OP_LD, 8'd9, 4'd1, 48'hdead), make_op(OP_LD, 8'd9, 4'd1, 48'hdead));
        send_op(make_op(OP_READ, 8'd9, 4'd0, 48'hbeef), make_op(OP_READ, 8'd9, 4'd0, 48'hbeef));
        load_reg(4'd1, MY_PE, 48'h0000_0010_0028);
        load_reg(4'd2, MY_PE, 48'h0000_0800_0000);
        load_reg(4'd0, BCAST, 48'h0000_0010_0000);
        read_reg(4'd0, MY_PE);
        read_reg(4'd1, BCAST);
        read_reg(4'd2, MY_PE);

        // seven values, only five fit before y_end
        for (int i = 0; i < 7; i++) begin
            v_rand = 64'h1111_0000_0000_0000 + 64'(i);
            push_cycle(1'b1, v_rand, 1'b0, '0);
        end
        push_cycle(1'b0, '0, 1'b0, '0);
        read_reg(4'd0, MY_PE);
        drain_requests();

        load_reg(4'd0, MY_PE, 48'h0000_0020_0000);
        load_reg(4'd1, MY_PE, 48'h0000_0020_0000 + 48'd2400);
        for (int i = 0; i < 10; i++) begin
            c_rand = $urandom;
            push_cycle(1'b0, '0, 1'b1, c_rand);
        end
        // same-cycle value and column
        for (int i = 0; i < 6; i++) begin
            v_rand[63:32] = $urandom;
            v_rand[31:0] = $urandom;
            c_rand = $urandom;
            push_cycle(1'b1, v_rand, 1'b1, c_rand);
        end
        drain_requests();

        // random traffic under memory stall
        for (int i = 0; i < 1200; i++) begin
            want_v = $urandom_range(0, 1);
            want_c = $urandom_range(0, 1);
            v_rand[63:32] = $urandom;
            v_rand[31:0] = $urandom;
            c_rand = $urandom;
            push_cycle(want_v, v_rand, want_c, c_rand);
            req_mem_stall = $urandom_range(0, 1);
        end
        req_mem_stall = 1'b0;
        drain_requests();

        // steady state and the busy chain
        load_reg(4'd0, MY_PE, 48'h0000_0030_0000);
        load_reg(4'd1, MY_PE, 48'h0000_0030_0010);
        busy_pass_chk = 1'b0;
        send_op(make_op(OP_STEADY, MY_PE, 4'd0, '0), make_op(OP_STEADY, MY_PE, 4'd0, '0));
        repeat (2) begin
            @(posedge clk);
            #2;
        end
        assert (busy_out)
            else begin
                errors++;
                $display("error: t=%0t busy_out got %b expected %b", $time, busy_out, 1'b1);
            end
        push_cycle(1'b1, 64'h2222_0000_0000_0001, 1'b0, '0);
        push_cycle(1'b1, 64'h2222_0000_0000_0002, 1'b0, '0);
        drain_requests();
        wait_cnt = 0;
        while (busy_out && wait_cnt < 40) begin
            @(posedge clk);
            #2;
            wait_cnt++;
        end
        assert (!busy_out)
            else begin
                errors++;
                $display("error: t=%0t busy_out still high 40 cycles after the FIFO drained",
                         $time);
            end
        busy_pass_chk = 1'b1;
        for (int i = 0; i < 30; i++) begin
            @(posedge clk);
            #2;
            busy_in = $urandom_range(0, 1);
        end
        busy_in = 1'b0;

        // soft reset clears all working registers
        send_op(make_op(OP_RST, MY_PE, 4'd0, '0), make_op(OP_RST, MY_PE, 4'd0, '0));
        reg_model[0] = '0;
        reg_model[1] = '0;
        reg_model[2] = '0;
        read_reg(4'd0, MY_PE);
        read_reg(4'd1, MY_PE);
        read_reg(4'd2, BCAST);

        repeat (4) @(posedge clk);
        if (exp_q.size() != 0 || held) begin
            errors++;
            $display("error: %0d expected requests never reached the memory port",
                     exp_q.size());
        end
        $display("requests checked %0d, errors %0d", n_req, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: compile.f
verilog/spmv_pkg.sv
verilog/std_fifo.sv
verilog/mem_request_gen.sv
verilog/mem_request_issuer.sv
verilog/pe_op_ring.sv
verilog/spmv_pe.sv
tests/spmv_pe_tb.sv
